// ==== mh_pkg.sv ====
`default_nettype none

package mh_pkg;

    // --------------------------------------------------
    // Sizes of the ML-DSA-87 hint component
    // --------------------------------------------------

    // Polynomials and coefficients per polynomial
    localparam int mlk = 8;
    localparam int mln = 256;
    localparam int coeff_w = 23;

    // Largest number of hints a valid signature may carry
    localparam int omega = 75;

    // Low-bits band limit and the full band width (2 * gamma2)
    localparam int gamma2 = 261888;
    localparam int alpha = 523776;

    // Memory and register address width
    localparam int addr_w = 10;

    // Four coefficients per memory word, so 64 reads cover one polynomial
    localparam int reads_per_poly = 64;

    // Dword layout of the 84-byte hint area.
    // Index bytes fill dwords 0 to 18, counts start at byte 75 inside dword 18
    localparam int count_dword = 18;
    localparam int h_dwords = 21;

    // Dwords needed to hold omega index bytes, the packer stops after these
    localparam int max_idx_dwords = 19;

    // --------------------------------------------------
    // Shared types
    // --------------------------------------------------

    typedef logic [addr_w-1:0] addr_t;

    // Byte 0 is the least significant byte of the dword
    typedef logic [3:0][7:0] dword_t;

    typedef logic [3:0][coeff_w-1:0] coeff_quad_t;

    // Read request to the coefficient and z flag memories
    typedef struct packed {
        logic  rd_en;
        addr_t addr;
    } mem_req_t;

    // One register write per cycle, always accepted
    typedef struct packed {
        logic       wr_en;
        addr_t      addr;
        logic [3:0] strb;
        dword_t     data;
    } reg_wr_t;

    // Controller sequence
    typedef enum logic [3:0] {
        mh_idle,
        mh_read,
        mh_drain1,
        mh_drain2,
        mh_flush,
        mh_zero_fill,
        mh_cnt0,
        mh_cnt1,
        mh_cnt2
    } mh_state_e;

endpackage

`default_nettype wire

// ==== hint_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module hint_gen (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        zeroize,
    input  wire                        enable,
    input  wire [mh_pkg::coeff_w-1:0]  coeff,
    input  wire                        z_flag,
    output logic                       hint
);

    // Band estimate taken from the top four bits of the coefficient
    logic [3:0]                 band;
    logic [mh_pkg::coeff_w-1:0] rem_est;
    logic [mh_pkg::coeff_w-1:0] rem;

    // Dividing by 2^19 instead of alpha can only undershoot the true
    // quotient, and by at most one for any 23-bit input
    assign band = coeff[mh_pkg::coeff_w-1 -: 4];

    assign rem_est = coeff - mh_pkg::coeff_w'(band * mh_pkg::alpha);

    // One correcting subtraction brings the remainder into [0, alpha)
    assign rem = (rem_est >= mh_pkg::coeff_w'(mh_pkg::alpha)) ?
                 rem_est - mh_pkg::coeff_w'(mh_pkg::alpha) : rem_est;

    // Hint is only ever high for one cycle per enabled coefficient
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hint <= 1'b0;
        end else if (zeroize) begin
            hint <= 1'b0;
        end else if (enable) begin
            hint <= z_flag && (rem > mh_pkg::coeff_w'(mh_pkg::gamma2));
        end else begin
            hint <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hint_index_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hint_index_packer (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   clear,
    input  wire  [3:0]            hint_valid,
    input  wire  [3:0][7:0]       index,
    input  wire                   flush,
    output logic                  word_valid,
    output mh_pkg::dword_t        word
);

    // Bytes left over after an emit, never more than three
    logic [2:0][7:0] hold;
    logic [1:0]      hold_cnt;

    // Held bytes with this cycle's valid bytes appended, up to seven
    logic [6:0][7:0] window;
    logic [2:0]      fill;

    // Dwords produced so far in this run
    logic [$clog2(mh_pkg::max_idx_dwords+1)-1:0] emitted;

    logic cap_hit;

    assign cap_hit = (emitted >= mh_pkg::max_idx_dwords);

    // --------------------------------------------------
    // Compaction of the valid lanes
    // --------------------------------------------------

    // Bytes above fill stay zero, which gives the padding on a flush
    always_comb begin
        window = '0;
        window[2:0] = hold;
        fill = {1'b0, hold_cnt};
        for (int i = 0; i < 4; i++) begin
            if (hint_valid[i]) begin
                window[fill] = index[i];
                fill = fill + 3'd1;
            end
        end
    end

    // --------------------------------------------------
    // Holding register and emit control
    // --------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hold       <= '0;
            hold_cnt   <= '0;
            word_valid <= 1'b0;
            emitted    <= '0;
        end else if (clear) begin
            hold       <= '0;
            hold_cnt   <= '0;
            word_valid <= 1'b0;
            emitted    <= '0;
        end else begin
            word_valid <= 1'b0;
            if (flush) begin
                // The controller only flushes once the hint pipeline is empty,
                // so at most three bytes are waiting here
                hold     <= '0;
                hold_cnt <= '0;
                if (fill != 3'd0 && !cap_hit) begin
                    word_valid <= 1'b1;
                    emitted    <= emitted + 1'b1;
                end
            end else if (fill >= 3'd4) begin
                hold     <= window[6:4];
                hold_cnt <= 2'(fill - 3'd4);
                // Past the cap the bytes are still consumed but never written
                if (!cap_hit) begin
                    word_valid <= 1'b1;
                    emitted    <= emitted + 1'b1;
                end
            end else begin
                hold     <= window[2:0];
                hold_cnt <= fill[1:0];
            end
        end
    end

    // Only meaningful while word_valid is high
    always_ff @(posedge clk) begin
        if (flush || fill >= 3'd4) begin
            word <= window[3:0];
        end
    end

endmodule

`default_nettype wire

// ==== makehint_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module makehint_ctrl (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   zeroize,
    input  wire                   start,
    input  wire                   busy,
    input  wire  mh_pkg::addr_t   mem_base,
    input  wire  mh_pkg::addr_t   dest_base,
    input  wire  [3:0]            hint,
    input  wire                   word_valid,
    input  wire  mh_pkg::dword_t  word,
    output mh_pkg::mem_req_t      mem_req,
    output logic                  hint_enable,
    output logic [3:0][7:0]       index,
    output logic                  pack_flush,
    output logic                  pack_clear,
    output mh_pkg::reg_wr_t       reg_wr,
    output logic [7:0]            hint_total,
    output logic                  run_end
);

    mh_pkg::mh_state_e state;
    mh_pkg::mh_state_e state_nxt;

    logic start_ok;

    // Read position, polynomial above read index within the polynomial
    logic [$clog2(mh_pkg::mlk)-1:0]            poly_cnt;
    logic [$clog2(mh_pkg::reads_per_poly)-1:0] rd_idx;
    logic                                      last_read;

    // Read index and polynomial end delayed to line up with the hints
    logic [$clog2(mh_pkg::reads_per_poly)-1:0] idx_d1;
    logic [$clog2(mh_pkg::reads_per_poly)-1:0] idx_d2;
    logic                                      poly_end_d1;
    logic                                      poly_end_d2;

    logic [2:0] hint_sum;
    logic [8:0] total_sum;
    logic [7:0] hint_total_nxt;

    // Cumulative total after each polynomial, entry 0 is polynomial 0
    logic [mh_pkg::mlk-1:0][7:0] count_buf;

    // Offset of the next index or zero-fill write, and of the current write
    logic [4:0] wr_offset;
    logic [4:0] wr_off;

    logic word_wr;
    logic zero_wr;
    logic cnt_wr;

    assign start_ok  = start && !busy;
    assign last_read = (state == mh_pkg::mh_read) &&
                       (rd_idx == mh_pkg::reads_per_poly - 1) &&
                       (poly_cnt == mh_pkg::mlk - 1);

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= mh_pkg::mh_idle;
        end else if (zeroize) begin
            state <= mh_pkg::mh_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            mh_pkg::mh_idle:    if (start_ok) state_nxt = mh_pkg::mh_read;
            mh_pkg::mh_read:    if (last_read) state_nxt = mh_pkg::mh_drain1;
            // Two cycles for the memory and hint stages to empty
            mh_pkg::mh_drain1:  state_nxt = mh_pkg::mh_drain2;
            mh_pkg::mh_drain2:  state_nxt = mh_pkg::mh_flush;
            mh_pkg::mh_flush:   state_nxt = mh_pkg::mh_zero_fill;
            // The flushed dword can still arrive in the first fill cycle
            mh_pkg::mh_zero_fill: begin
                if (!word_valid && wr_offset >= mh_pkg::count_dword - 1) begin
                    state_nxt = mh_pkg::mh_cnt0;
                end
            end
            mh_pkg::mh_cnt0:    state_nxt = mh_pkg::mh_cnt1;
            mh_pkg::mh_cnt1:    state_nxt = mh_pkg::mh_cnt2;
            mh_pkg::mh_cnt2:    state_nxt = mh_pkg::mh_idle;
            default:            state_nxt = mh_pkg::mh_idle;
        endcase
    end

    // All eight polynomials are read back to back as one 512-read sweep
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            poly_cnt <= '0;
            rd_idx   <= '0;
        end else if (zeroize || start_ok) begin
            poly_cnt <= '0;
            rd_idx   <= '0;
        end else if (state == mh_pkg::mh_read) begin
            {poly_cnt, rd_idx} <= {poly_cnt, rd_idx} + 1'b1;
        end
    end

    assign mem_req.rd_en = (state == mh_pkg::mh_read);
    assign mem_req.addr  = mem_base + mh_pkg::addr_t'({poly_cnt, rd_idx});

    // --------------------------------------------------
    // Hint alignment and counting
    // --------------------------------------------------

    // Read data lands one cycle after the request, hints one cycle later
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hint_enable <= 1'b0;
            poly_end_d1 <= 1'b0;
            poly_end_d2 <= 1'b0;
        end else if (zeroize) begin
            hint_enable <= 1'b0;
            poly_end_d1 <= 1'b0;
            poly_end_d2 <= 1'b0;
        end else begin
            hint_enable <= (state == mh_pkg::mh_read);
            poly_end_d1 <= (state == mh_pkg::mh_read) &&
                           (rd_idx == mh_pkg::reads_per_poly - 1);
            poly_end_d2 <= poly_end_d1;
        end
    end

    always_ff @(posedge clk) begin
        idx_d1 <= rd_idx;
        idx_d2 <= idx_d1;
    end

    // Four consecutive coefficient indices, wrapping at 256 per polynomial
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            index[i] = {idx_d2, 2'b00} + 8'(i);
        end
    end

    assign hint_sum  = 3'(hint[0]) + 3'(hint[1]) + 3'(hint[2]) + 3'(hint[3]);
    assign total_sum = 9'(hint_total) + 9'(hint_sum);

    // Saturates at 255 so the omega check never wraps
    assign hint_total_nxt = total_sum[8] ? 8'hff : total_sum[7:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hint_total <= '0;
        end else if (zeroize || start_ok) begin
            hint_total <= '0;
        end else begin
            hint_total <= hint_total_nxt;
        end
    end

    // The last hints of a polynomial arrive together with poly_end_d2
    always_ff @(posedge clk) begin
        if (poly_end_d2) begin
            count_buf <= {hint_total_nxt, count_buf[mh_pkg::mlk-1:1]};
        end
    end

    // --------------------------------------------------
    // Register writes
    // --------------------------------------------------

    assign word_wr = word_valid;
    assign zero_wr = (state == mh_pkg::mh_zero_fill) && !word_valid &&
                     (wr_offset < mh_pkg::count_dword);
    assign cnt_wr  = (state == mh_pkg::mh_cnt0) || (state == mh_pkg::mh_cnt1) ||
                     (state == mh_pkg::mh_cnt2);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_offset <= '0;
        end else if (zeroize || start_ok) begin
            wr_offset <= '0;
        end else if (word_wr || zero_wr) begin
            wr_offset <= wr_offset + 5'd1;
        end
    end

    always_comb begin
        wr_off      = wr_offset;
        reg_wr.strb = 4'b1111;
        reg_wr.data = word_valid ? word : '0;
        case (state)
            // Byte 75 only, bytes 72 to 74 keep their index values
            mh_pkg::mh_cnt0: begin
                wr_off      = 5'(mh_pkg::count_dword);
                reg_wr.strb = 4'b1000;
                reg_wr.data = {count_buf[0], 24'h0};
            end
            mh_pkg::mh_cnt1: begin
                wr_off      = 5'(mh_pkg::count_dword + 1);
                reg_wr.data = count_buf[4:1];
            end
            // Byte 83 is always zero
            mh_pkg::mh_cnt2: begin
                wr_off      = 5'(mh_pkg::count_dword + 2);
                reg_wr.data = {8'h0, count_buf[7:5]};
            end
            default: begin
            end
        endcase
        reg_wr.wr_en = word_wr || zero_wr || cnt_wr;
        reg_wr.addr  = dest_base + mh_pkg::addr_t'(wr_off);
    end

    assign pack_flush = (state == mh_pkg::mh_flush);
    assign pack_clear = zeroize || start_ok;
    assign run_end    = (state == mh_pkg::mh_cnt2);

endmodule

`default_nettype wire

// ==== makehint_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module makehint_regs (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  zeroize,
    input  wire                  start,
    input  wire                  run_end,
    input  wire  mh_pkg::addr_t  mem_base_addr,
    input  wire  mh_pkg::addr_t  dest_base_addr,
    input  wire  [7:0]           hint_total,
    output mh_pkg::addr_t        mem_base,
    output mh_pkg::addr_t        dest_base,
    output logic                 busy,
    output logic                 invalid_h,
    output logic                 done
);

    // A start while a run is in progress has no effect
    logic start_ok;

    assign start_ok = start && !busy;

    // --------------------------------------------------
    // Run status and sticky invalid flag
    // --------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy      <= 1'b0;
            invalid_h <= 1'b0;
            done      <= 1'b0;
        end else if (zeroize) begin
            busy      <= 1'b0;
            invalid_h <= 1'b0;
            done      <= 1'b0;
        end else begin
            // done follows the last count write by one cycle
            done <= run_end;
            if (start_ok) begin
                busy      <= 1'b1;
                invalid_h <= 1'b0;
            end else begin
                if (run_end) begin
                    busy <= 1'b0;
                end
                // Stays set after the run so software can still see it
                if (hint_total > mh_pkg::omega) begin
                    invalid_h <= 1'b1;
                end
            end
        end
    end

    // Bases are held for the whole run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_base  <= '0;
            dest_base <= '0;
        end else if (start_ok) begin
            mem_base  <= mem_base_addr;
            dest_base <= dest_base_addr;
        end
    end

endmodule

`default_nettype wire

// ==== makehint_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module makehint_top (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        zeroize,
    input  wire                        start,
    input  wire  mh_pkg::addr_t        mem_base_addr,
    input  wire  mh_pkg::addr_t        dest_base_addr,
    input  wire  mh_pkg::coeff_quad_t  r_data,
    input  wire  [3:0]                 z_flags,
    output mh_pkg::mem_req_t           mem_req,
    output mh_pkg::reg_wr_t            reg_wr,
    output logic                       done,
    output logic                       invalid_h
);

    // Register block to controller
    mh_pkg::addr_t mem_base;
    mh_pkg::addr_t dest_base;
    logic          busy;

    // Controller back to the register block
    logic       run_end;
    logic [7:0] hint_total;

    // Hint path
    logic            hint_enable;
    logic [3:0]      hint;
    logic [3:0][7:0] index;

    // Packer handshake
    logic           pack_flush;
    logic           pack_clear;
    logic           word_valid;
    mh_pkg::dword_t word;

    makehint_regs regs_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .start          (start),
        .run_end        (run_end),
        .mem_base_addr  (mem_base_addr),
        .dest_base_addr (dest_base_addr),
        .hint_total     (hint_total),
        .mem_base       (mem_base),
        .dest_base      (dest_base),
        .busy           (busy),
        .invalid_h      (invalid_h),
        .done           (done)
    );

    makehint_ctrl ctrl_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .start       (start),
        .busy        (busy),
        .mem_base    (mem_base),
        .dest_base   (dest_base),
        .hint        (hint),
        .word_valid  (word_valid),
        .word        (word),
        .mem_req     (mem_req),
        .hint_enable (hint_enable),
        .index       (index),
        .pack_flush  (pack_flush),
        .pack_clear  (pack_clear),
        .reg_wr      (reg_wr),
        .hint_total  (hint_total),
        .run_end     (run_end)
    );

    // One hint generator per coefficient lane of the memory word
    for (genvar i = 0; i < 4; i++) begin : g_hint
        hint_gen hint_gen_inst (
            .clk     (clk),
            .reset_n (reset_n),
            .zeroize (zeroize),
            .enable  (hint_enable),
            .coeff   (r_data[i]),
            .z_flag  (z_flags[i]),
            .hint    (hint[i])
        );
    end

    hint_index_packer packer_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .clear      (pack_clear),
        .hint_valid (hint),
        .index      (index),
        .flush      (pack_flush),
        .word_valid (word_valid),
        .word       (word)
    );

endmodule

`default_nettype wire

// ==== makehint_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module makehint_checker (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   done,
    input  wire                   busy,
    input  wire  mh_pkg::mem_req_t mem_req,
    input  wire  mh_pkg::reg_wr_t  reg_wr,
    input  wire  mh_pkg::addr_t    dest_base
);

    // Failures seen so far, summed into the testbench's error total
    int unsigned assert_fails = 0;

    // --------------------------------------------------
    // Protocol properties of the top level
    // --------------------------------------------------

    // The done strobe is a single cycle wide
    done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done)
    else begin
        $error("done stayed high for more than one cycle");
        assert_fails++;
    end

    // Reads only happen inside a run
    read_while_busy: assert property (@(posedge clk) disable iff (!reset_n)
        mem_req.rd_en |-> busy)
    else begin
        $error("memory read issued while not busy");
        assert_fails++;
    end

    // Every write lands inside the 21-dword hint area
    write_in_area: assert property (@(posedge clk) disable iff (!reset_n)
        reg_wr.wr_en |-> (mh_pkg::addr_t'(reg_wr.addr - dest_base) < mh_pkg::h_dwords))
    else begin
        $error("register write offset outside the hint area");
        assert_fails++;
    end

endmodule

bind makehint_top makehint_checker checker_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .done      (done),
    .busy      (busy),
    .mem_req   (mem_req),
    .reg_wr    (reg_wr),
    .dest_base (dest_base)
);

`default_nettype wire

// ==== makehint_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module makehint_tb;

    // Five full runs of at most about 600 cycles each, with margin for gaps
    localparam int cycle_limit = 4000;

    logic                clk;
    logic                reset_n;
    logic                zeroize;
    logic                start;
    mh_pkg::addr_t       mem_base_addr;
    mh_pkg::addr_t       dest_base_addr;
    mh_pkg::coeff_quad_t r_data;
    logic [3:0]          z_flags;
    mh_pkg::mem_req_t    mem_req;
    mh_pkg::reg_wr_t     reg_wr;
    logic                done;
    logic                invalid_h;

    // Coefficient and z flag memories, both indexed by read offset
    mh_pkg::coeff_quad_t coeff_mem [0:511];
    logic [3:0]          z_mem [0:511];

    // Request seen at the falling edge, answered at the next rising edge
    logic          req_valid;
    mh_pkg::addr_t req_off;

    // Image built from the writes, and the one the reference predicts
    logic [7:0]    cap_bytes [0:83];
    logic          cap_written [0:83];
    logic [7:0]    exp_bytes [0:83];
    int            exp_total;
    mh_pkg::addr_t cur_dest;

    int seed = 32'h24fd;
    int err_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int err_total;

    makehint_top makehint_top_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .start          (start),
        .mem_base_addr  (mem_base_addr),
        .dest_base_addr (dest_base_addr),
        .r_data         (r_data),
        .z_flags        (z_flags),
        .mem_req        (mem_req),
        .reg_wr         (reg_wr),
        .done           (done),
        .invalid_h      (invalid_h)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit, counted in rising edges
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // --------------------------------------------------
    // Memory model and write capture
    // --------------------------------------------------

    always @(negedge clk) begin
        req_valid <= mem_req.rd_en;
        req_off   <= mem_req.addr - mem_base_addr;
    end

    // Fixed one-cycle read latency
    always @(posedge clk) begin
        if (req_valid) begin
            r_data  <= coeff_mem[req_off[8:0]];
            z_flags <= z_mem[req_off[8:0]];
        end
    end

    // Byte strobes decide which bytes of the image a write touches
    always @(negedge clk) begin
        if (reset_n && reg_wr.wr_en) begin
            compare_addr(reg_wr.addr, cur_dest);
            capture_write(reg_wr);
        end
    end

    task automatic capture_write(input mh_pkg::reg_wr_t wr);
        mh_pkg::addr_t off;
        off = wr.addr - cur_dest;
        if (off < mh_pkg::h_dwords) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.strb[b]) begin
                    cap_bytes[4 * off + b]   = wr.data[b];
                    cap_written[4 * off + b] = 1'b1;
                end
            end
        end
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------

    task automatic compare_word(input mh_pkg::dword_t got, input mh_pkg::dword_t exp,
                                input int dw);
        if (got !== exp) begin
            $display("error at %0t: dword %0d is %h, expected %h", $time, dw, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_addr(input mh_pkg::addr_t got, input mh_pkg::addr_t base);
        if (mh_pkg::addr_t'(got - base) >= mh_pkg::h_dwords) begin
            $display("error at %0t: write address %h outside area at %h", $time, got, base);
            err_count++;
        end
    endtask

    // --------------------------------------------------
    // Stimulus and reference model
    // --------------------------------------------------

    // A coefficient whose remainder mod alpha lies above or below gamma2
    function automatic logic [mh_pkg::coeff_w-1:0] make_coeff(input logic high);
        int band;
        int low;
        band = ($random(seed) & 32'h7fffffff) % 16;
        if (high) begin
            low = mh_pkg::gamma2 + 1 +
                  ($random(seed) & 32'h7fffffff) % (mh_pkg::alpha - mh_pkg::gamma2 - 1);
        end else begin
            low = ($random(seed) & 32'h7fffffff) % (mh_pkg::gamma2 + 1);
        end
        return mh_pkg::coeff_w'(band * mh_pkg::alpha + low);
    endfunction

    // Random coefficients, z set with probability z_thresh / 256
    task automatic fill_random(input int z_thresh);
        for (int n = 0; n < 512; n++) begin
            for (int l = 0; l < 4; l++) begin
                coeff_mem[n][l] = mh_pkg::coeff_w'($random(seed));
                z_mem[n][l]     = (($random(seed) & 255) < z_thresh);
            end
        end
    endtask

    // Exactly count hints, one every step coefficients across the sweep
    task automatic fill_placed(input int count, input int step);
        int j;
        for (int n = 0; n < 512; n++) begin
            for (int l = 0; l < 4; l++) begin
                coeff_mem[n][l] = make_coeff(1'b0);
                z_mem[n][l]     = $random(seed) & 1;
            end
        end
        for (int k = 0; k < count; k++) begin
            j = k * step;
            coeff_mem[j / 4][j % 4] = make_coeff(1'b1);
            z_mem[j / 4][j % 4]     = 1'b1;
        end
    endtask

    // Hint rule, index packing up to omega bytes, counts from byte 75
    task automatic build_expected();
        int fill;
        int total;
        int j;
        logic [mh_pkg::coeff_w-1:0] c;
        fill  = 0;
        total = 0;
        for (int b = 0; b < 84; b++) begin
            exp_bytes[b] = 8'h00;
        end
        for (int p = 0; p < mh_pkg::mlk; p++) begin
            for (int i = 0; i < mh_pkg::mln; i++) begin
                j = p * mh_pkg::mln + i;
                c = coeff_mem[j / 4][j % 4];
                if (z_mem[j / 4][j % 4] && (int'(c) % mh_pkg::alpha > mh_pkg::gamma2)) begin
                    if (fill < mh_pkg::omega) begin
                        exp_bytes[fill] = 8'(i);
                        fill++;
                    end
                    total++;
                end
            end
            exp_bytes[4 * mh_pkg::count_dword + 3 + p] = (total > 255) ? 8'hff : 8'(total);
        end
        exp_total = total;
    endtask

    task automatic launch_run(input mh_pkg::addr_t mbase, input mh_pkg::addr_t dbase);
        for (int b = 0; b < 84; b++) begin
            cap_bytes[b]   = 8'h00;
            cap_written[b] = 1'b0;
        end
        cur_dest = dbase;
        @(posedge clk);
        mem_base_addr  <= mbase;
        dest_base_addr <= dbase;
        start          <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        while (!done) begin
            @(negedge clk);
        end
    endtask

    task automatic check_image();
        mh_pkg::dword_t got_w;
        mh_pkg::dword_t exp_w;
        int missing;
        missing = 0;
        build_expected();
        for (int d = 0; d < mh_pkg::h_dwords; d++) begin
            for (int b = 0; b < 4; b++) begin
                got_w[b] = cap_bytes[4 * d + b];
                exp_w[b] = exp_bytes[4 * d + b];
            end
            compare_word(got_w, exp_w, d);
        end
        // Bytes 72 to 74 carry only index bytes and are left alone otherwise
        for (int b = 0; b < 84; b++) begin
            if ((b < 72 || b >= 75) && !cap_written[b]) begin
                missing++;
            end
        end
        if (missing != 0) begin
            $display("%0d bytes of the hint area were never written", missing);
            err_count++;
        end
        compare_flag(invalid_h, exp_total > mh_pkg::omega, "invalid_h after done");
    endtask

    task automatic run_and_check(input mh_pkg::addr_t mbase, input mh_pkg::addr_t dbase);
        launch_run(mbase, dbase);
        wait_done();
        check_image();
        repeat (4) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic idle_z_flags();
        int errs_before;
        errs_before = err_count;
        fill_random(0);
        run_and_check(10'h100, 10'h200);
        finish_test("no hints", errs_before);
    endtask

    task automatic sparse_pattern();
        int errs_before;
        errs_before = err_count;
        fill_random(10);
        run_and_check(10'h000, 10'h3e0);
        finish_test("sparse hints", errs_before);
    endtask

    task automatic exact_omega();
        int errs_before;
        errs_before = err_count;
        fill_placed(mh_pkg::omega, 27);
        run_and_check(10'h200, 10'h020);
        finish_test("exactly omega hints", errs_before);
    endtask

    // The flag has to survive the end of the run
    task automatic beyond_omega();
        int errs_before;
        errs_before = err_count;
        fill_placed(90, 22);
        run_and_check(10'h080, 10'h300);
        repeat (5) @(negedge clk);
        compare_flag(invalid_h, 1'b1, "invalid_h held after run");
        finish_test("beyond omega", errs_before);
    endtask

    task automatic zeroize_abort();
        int   errs_before;
        logic seen_req;
        logic seen_wr;
        logic seen_done;
        errs_before = err_count;
        seen_req    = 1'b0;
        seen_wr     = 1'b0;
        seen_done   = 1'b0;
        fill_placed(90, 22);
        launch_run(10'h040, 10'h180);
        @(negedge clk);
        compare_flag(invalid_h, 1'b0, "invalid_h cleared by start");
        // Abort once the overflow has been flagged
        while (!invalid_h) begin
            @(negedge clk);
        end
        @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        repeat (40) begin
            @(negedge clk);
            seen_req  = seen_req | mem_req.rd_en;
            seen_wr   = seen_wr | reg_wr.wr_en;
            seen_done = seen_done | done;
        end
        compare_flag(seen_req, 1'b0, "read request after zeroize");
        compare_flag(seen_wr, 1'b0, "register write after zeroize");
        compare_flag(seen_done, 1'b0, "done after zeroize");
        compare_flag(invalid_h, 1'b0, "invalid_h after zeroize");
        fill_random(10);
        run_and_check(10'h000, 10'h3e8);
        finish_test("zeroize mid run", errs_before);
    endtask

    initial begin
        reset_n        = 1'b0;
        zeroize        = 1'b0;
        start          = 1'b0;
        mem_base_addr  = '0;
        dest_base_addr = '0;
        r_data         = '0;
        z_flags        = '0;
        cur_dest       = '0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);

        idle_z_flags();
        sparse_pattern();
        exact_omega();
        beyond_omega();
        zeroize_abort();

        err_total = err_count + makehint_top_inst.checker_inst.assert_fails;
        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_count,
                 makehint_top_inst.checker_inst.assert_fails);
        if (err_total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
mh_pkg.sv
hint_gen.sv
hint_index_packer.sv
makehint_ctrl.sv
makehint_regs.sv
makehint_top.sv
makehint_checker.sv
makehint_tb.sv
